/* cache_pkg.sv */
package cache_pkg;

    // word address into the data array.
    localparam int addr_bits = 10;

    // a full line as seen by the store and load clients.
    localparam int line_bits = 128;

    // one SRAM word, which is also one beat of a line.
    localparam int word_bits = 32;

    localparam int beats_per_line = line_bits / word_bits;

    localparam int id_bits = 2;

    typedef logic [addr_bits-1:0] cache_addr_t;

    // beat 0 sits in the lowest bits of the line.
    typedef logic [line_bits-1:0] cache_line_t;

    typedef logic [word_bits-1:0] cache_word_t;

    typedef logic [id_bits-1:0] req_id_t;

    // the extra top bit flags that the last beat is done.
    typedef logic [$clog2(beats_per_line):0] beat_idx_t;

    typedef enum logic [1:0] {
        rd_idle,
        rd_issue,
        rd_drain
    } rd_state_t;

endpackage

/* cache_sram.sv */
`timescale 1ns/1ps

module cache_sram
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        ce_n,
    input  logic        we_n,
    input  cache_addr_t addr,
    input  cache_word_t wdata,
    output cache_word_t rdata
);

    cache_word_t mem [2**addr_bits];

    // Writes land at the edge. A read registers its word, which is
    // then held until the next read cycle.
    always_ff @(posedge clk) begin
        if (!ce_n) begin
            if (!we_n) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

/* cache_port_arbiter.sv */
`timescale 1ns/1ps

module cache_port_arbiter
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        wr_port_req,
    input  logic        rd_port_req,
    output logic        wr_port_ready,
    output logic        rd_port_ready,

    input  logic        wr_ce_n,
    input  logic        wr_we_n,
    input  cache_addr_t wr_addr,
    input  cache_word_t wr_wdata,
    input  logic        rd_ce_n,
    input  cache_addr_t rd_addr,

    output logic        sram_ce_n,
    output logic        sram_we_n,
    output cache_addr_t sram_addr,
    output cache_word_t sram_wdata
);

    logic last_grant; // high when the write side won the last granted cycle.

    assign wr_port_ready = wr_port_req && (!rd_port_req || !last_grant);
    assign rd_port_ready = rd_port_req && (!wr_port_req || last_grant);

    always_comb begin
        sram_ce_n  = 1'b1;
        sram_we_n  = 1'b1;
        sram_addr  = '0;
        sram_wdata = '0;
        if (wr_port_ready) begin
            sram_ce_n  = wr_ce_n;
            sram_we_n  = wr_we_n;
            sram_addr  = wr_addr;
            sram_wdata = wr_wdata;
        end else if (rd_port_ready) begin
            sram_ce_n = rd_ce_n;
            sram_addr = rd_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_grant <= 1'b1; // so the read side wins the first conflict.
        end else if (wr_port_ready) begin
            last_grant <= 1'b1;
        end else if (rd_port_ready) begin
            last_grant <= 1'b0;
        end
    end

    a_one_grant : assert property (
        @(posedge clk) disable iff (rst) !(wr_port_ready && rd_port_ready)
    );

endmodule

/* cache_write_interface.sv */
`timescale 1ns/1ps

module cache_write_interface
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    output logic        wr_ready,
    input  logic        wr_valid,
    input  cache_addr_t wr_addr,
    input  cache_line_t wr_data,
    input  req_id_t     wr_id,

    output logic        wr_ack_valid,
    output req_id_t     wr_ack_id,

    output logic        port_req,
    input  logic        port_ready,
    output logic        port_ce_n,
    output logic        port_we_n,
    output cache_addr_t port_addr,
    output cache_word_t port_wdata
);

    logic        cur_valid;
    logic        cur_valid_nxt;
    cache_line_t cur_data;
    cache_line_t cur_data_nxt;
    cache_addr_t cur_addr;
    cache_addr_t cur_addr_nxt;
    beat_idx_t   cur_idx;
    beat_idx_t   cur_idx_nxt;
    req_id_t     cur_id;
    req_id_t     cur_id_nxt;
    logic        write_last;

    assign wr_ready = !cur_valid;
    assign port_req = cur_valid || wr_valid; // a line being accepted asks for the port at once.

    always_comb begin
        cur_valid_nxt = cur_valid;
        cur_data_nxt  = cur_data;
        cur_addr_nxt  = cur_addr;
        cur_idx_nxt   = cur_idx;
        cur_id_nxt    = cur_id;
        write_last    = 1'b0;

        if (wr_ready && wr_valid) begin
            cur_valid_nxt = 1'b1;
            cur_data_nxt  = wr_data;
            cur_addr_nxt  = wr_addr;
            cur_idx_nxt   = '0;
            cur_id_nxt    = wr_id;
        end

        port_ce_n  = 1'b1;
        port_we_n  = 1'b1;
        port_addr  = '0;
        port_wdata = '0;

        if (cur_valid_nxt && port_ready) begin
            port_ce_n   = 1'b0;
            port_we_n   = 1'b0;
            port_addr   = cur_addr_nxt + cache_addr_t'(cur_idx_nxt); // wraps at the array end.
            port_wdata  = cur_data_nxt[cur_idx_nxt * word_bits +: word_bits];
            cur_idx_nxt = cur_idx_nxt + 1'b1;
            if (cur_idx_nxt[$bits(beat_idx_t)-1]) begin
                write_last    = 1'b1;
                cur_valid_nxt = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_valid    <= 1'b0;
            wr_ack_valid <= 1'b0;
        end else begin
            cur_valid    <= cur_valid_nxt;
            wr_ack_valid <= write_last;
        end
    end

    always_ff @(posedge clk) begin
        cur_data <= cur_data_nxt;
        cur_addr <= cur_addr_nxt;
        cur_idx  <= cur_idx_nxt;
        cur_id   <= cur_id_nxt;
        if (write_last) begin
            wr_ack_id <= cur_id_nxt;
        end
    end

    a_no_ce_without_grant : assert property (
        @(posedge clk) disable iff (rst) !port_ready |-> port_ce_n
    );

endmodule

/* cache_read_interface.sv */
`timescale 1ns/1ps

module cache_read_interface
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    output logic        rd_ready,
    input  logic        rd_valid,
    input  cache_addr_t rd_addr,
    input  req_id_t     rd_id,

    output logic        rd_resp_valid,
    output req_id_t     rd_resp_id,
    output cache_line_t rd_resp_data,

    output logic        port_req,
    input  logic        port_ready,
    output logic        port_ce_n,
    output cache_addr_t port_addr,
    input  cache_word_t port_rdata
);

    rd_state_t   state;
    rd_state_t   state_nxt;
    beat_idx_t   issue_idx;
    beat_idx_t   issue_idx_nxt;
    logic        issue;
    cache_addr_t base_addr;
    req_id_t     cur_id;
    cache_line_t line_buf;

    // the word of the beat read in the previous cycle is on port_rdata now.
    logic        prev_valid;
    beat_idx_t   prev_idx;

    assign rd_ready     = (state == rd_idle);
    assign port_req     = (state == rd_issue);
    assign rd_resp_id   = cur_id;
    assign rd_resp_data = line_buf; // stable through the response cycle.

    always_comb begin
        state_nxt     = state;
        issue_idx_nxt = issue_idx;
        issue         = 1'b0;
        port_ce_n     = 1'b1;
        port_addr     = '0;

        case (state)
            rd_idle: begin
                if (rd_valid) begin
                    state_nxt     = rd_issue;
                    issue_idx_nxt = '0;
                end
            end
            rd_issue: begin
                if (port_ready) begin
                    issue         = 1'b1;
                    port_ce_n     = 1'b0;
                    port_addr     = base_addr + cache_addr_t'(issue_idx);
                    issue_idx_nxt = issue_idx + 1'b1;
                    if (issue_idx_nxt[$bits(beat_idx_t)-1]) begin
                        state_nxt = rd_drain;
                    end
                end
            end
            rd_drain: state_nxt = rd_idle; // last word lands in line_buf here.
            default:  state_nxt = rd_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= rd_idle;
            issue_idx     <= '0;
            prev_valid    <= 1'b0;
            rd_resp_valid <= 1'b0;
        end else begin
            state         <= state_nxt;
            issue_idx     <= issue_idx_nxt;
            prev_valid    <= issue;
            rd_resp_valid <= (state == rd_drain);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_ready && rd_valid) begin
            base_addr <= rd_addr;
            cur_id    <= rd_id;
        end
        prev_idx <= issue_idx;
        if (prev_valid) begin
            line_buf[prev_idx * word_bits +: word_bits] <= port_rdata;
        end
    end

    a_resp_single_pulse : assert property (
        @(posedge clk) disable iff (rst) rd_resp_valid |=> !rd_resp_valid
    );

endmodule

/* cache_subsystem.sv */
`timescale 1ns/1ps

module cache_subsystem
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    output logic        wr_ready,
    input  logic        wr_valid,
    input  cache_addr_t wr_addr,
    input  cache_line_t wr_data,
    input  req_id_t     wr_id,
    output logic        wr_ack_valid,
    output req_id_t     wr_ack_id,

    output logic        rd_ready,
    input  logic        rd_valid,
    input  cache_addr_t rd_addr,
    input  req_id_t     rd_id,
    output logic        rd_resp_valid,
    output req_id_t     rd_resp_id,
    output cache_line_t rd_resp_data
);

    logic        wr_port_req;
    logic        wr_port_ready;
    logic        wr_port_ce_n;
    logic        wr_port_we_n;
    cache_addr_t wr_port_addr;
    cache_word_t wr_port_wdata;

    logic        rd_port_req;
    logic        rd_port_ready;
    logic        rd_port_ce_n;
    cache_addr_t rd_port_addr;

    logic        sram_ce_n;
    logic        sram_we_n;
    cache_addr_t sram_addr;
    cache_word_t sram_wdata;
    cache_word_t sram_rdata;

    cache_write_interface u_write (
        .clk          (clk),
        .rst          (rst),
        .wr_ready     (wr_ready),
        .wr_valid     (wr_valid),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .wr_id        (wr_id),
        .wr_ack_valid (wr_ack_valid),
        .wr_ack_id    (wr_ack_id),
        .port_req     (wr_port_req),
        .port_ready   (wr_port_ready),
        .port_ce_n    (wr_port_ce_n),
        .port_we_n    (wr_port_we_n),
        .port_addr    (wr_port_addr),
        .port_wdata   (wr_port_wdata)
    );

    cache_read_interface u_read (
        .clk           (clk),
        .rst           (rst),
        .rd_ready      (rd_ready),
        .rd_valid      (rd_valid),
        .rd_addr       (rd_addr),
        .rd_id         (rd_id),
        .rd_resp_valid (rd_resp_valid),
        .rd_resp_id    (rd_resp_id),
        .rd_resp_data  (rd_resp_data),
        .port_req      (rd_port_req),
        .port_ready    (rd_port_ready),
        .port_ce_n     (rd_port_ce_n),
        .port_addr     (rd_port_addr),
        .port_rdata    (sram_rdata)
    );

    cache_port_arbiter u_arbiter (
        .clk           (clk),
        .rst           (rst),
        .wr_port_req   (wr_port_req),
        .rd_port_req   (rd_port_req),
        .wr_port_ready (wr_port_ready),
        .rd_port_ready (rd_port_ready),
        .wr_ce_n       (wr_port_ce_n),
        .wr_we_n       (wr_port_we_n),
        .wr_addr       (wr_port_addr),
        .wr_wdata      (wr_port_wdata),
        .rd_ce_n       (rd_port_ce_n),
        .rd_addr       (rd_port_addr),
        .sram_ce_n     (sram_ce_n),
        .sram_we_n     (sram_we_n),
        .sram_addr     (sram_addr),
        .sram_wdata    (sram_wdata)
    );

    cache_sram u_sram (
        .clk   (clk),
        .ce_n  (sram_ce_n),
        .we_n  (sram_we_n),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

endmodule

/* tb_cache_subsystem.sv */
`timescale 1ns/1ps

module tb_cache_subsystem
    import cache_pkg::*;
();

    localparam int random_ops  = 94;
    localparam int cycle_limit = 4000; // 200 operations at about 12 cycles each, plus margin.

    logic        clk = 1'b0;
    logic        rst;
    logic        wr_ready;
    logic        wr_valid;
    cache_addr_t wr_addr;
    cache_line_t wr_data;
    req_id_t     wr_id;
    logic        wr_ack_valid;
    req_id_t     wr_ack_id;
    logic        rd_ready;
    logic        rd_valid;
    cache_addr_t rd_addr;
    req_id_t     rd_id;
    logic        rd_resp_valid;
    req_id_t     rd_resp_id;
    cache_line_t rd_resp_data;

    cache_word_t model [2**addr_bits];
    logic        model_valid [2**addr_bits];
    req_id_t     exp_wr_id [$];
    int          exp_wr_cycle [$]; // acceptance cycle, or -1 when latency is not checked.
    req_id_t     exp_rd_id [$];
    cache_line_t exp_rd_line [$];
    cache_addr_t written_bases [$];

    integer      seed = 32'h7a3d_2cea;
    int          errors = 0;
    int          cycle_count = 0;
    logic        check_latency = 1'b0;
    logic        wr_busy = 1'b0;
    logic        wr_taken = 1'b0;
    logic        rd_busy = 1'b0;
    logic        rd_taken = 1'b0;
    cache_addr_t wr_busy_addr;
    cache_addr_t rd_busy_addr;
    req_id_t     next_wr_id = '0;
    req_id_t     next_rd_id = '0;

    cache_subsystem UUT (
        .clk           (clk),
        .rst           (rst),
        .wr_ready      (wr_ready),
        .wr_valid      (wr_valid),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_id         (wr_id),
        .wr_ack_valid  (wr_ack_valid),
        .wr_ack_id     (wr_ack_id),
        .rd_ready      (rd_ready),
        .rd_valid      (rd_valid),
        .rd_addr       (rd_addr),
        .rd_id         (rd_id),
        .rd_resp_valid (rd_resp_valid),
        .rd_resp_id    (rd_resp_id),
        .rd_resp_data  (rd_resp_data)
    );

    always #50 clk = ~clk;

    // beat k of the line at addr comes from word addr plus k, wrapping at the array end.
    function automatic cache_line_t expected_line(input cache_addr_t addr);
        cache_line_t line;
        cache_addr_t a;
        int          k;
        for (k = 0; k < beats_per_line; k++) begin
            a = addr + cache_addr_t'(k);
            line[k*word_bits +: word_bits] = model[a];
        end
        return line;
    endfunction

    function automatic logic line_written(input cache_addr_t addr);
        logic        ok;
        cache_addr_t a;
        int          k;
        ok = 1'b1;
        for (k = 0; k < beats_per_line; k++) begin
            a = addr + cache_addr_t'(k);
            ok = ok && model_valid[a];
        end
        return ok;
    endfunction

    function automatic logic lines_overlap(input cache_addr_t a, input cache_addr_t b);
        cache_addr_t d_ab;
        cache_addr_t d_ba;
        d_ab = a - b;
        d_ba = b - a;
        return (d_ab < beats_per_line) || (d_ba < beats_per_line);
    endfunction

    function automatic cache_line_t random_line();
        cache_line_t line;
        int          k;
        for (k = 0; k < beats_per_line; k++) begin
            line[k*word_bits +: word_bits] = $random(seed);
        end
        return line;
    endfunction

    task automatic start_write(input cache_addr_t addr, input cache_line_t data);
        wr_addr      = addr;
        wr_data      = data;
        wr_id        = next_wr_id;
        next_wr_id   = next_wr_id + 1'b1;
        wr_valid     = 1'b1;
        wr_busy      = 1'b1;
        wr_busy_addr = addr;
    endtask

    task automatic start_read(input cache_addr_t addr);
        rd_addr      = addr;
        rd_id        = next_rd_id;
        next_rd_id   = next_rd_id + 1'b1;
        rd_valid     = 1'b1;
        rd_busy      = 1'b1;
        rd_busy_addr = addr;
    endtask

    // drops a request that was taken at the rising edge just passed.
    task automatic next_cycle();
        @(negedge clk);
        if (wr_taken) begin
            wr_valid = 1'b0;
            wr_taken = 1'b0;
        end
        if (rd_taken) begin
            rd_valid = 1'b0;
            rd_taken = 1'b0;
        end
    endtask

    // Ready is a register output, so valid and ready seen here decide the coming edge.
    task automatic note_acceptance();
        cache_addr_t a;
        int          k;
        if (wr_valid && wr_ready) begin
            for (k = 0; k < beats_per_line; k++) begin
                a = wr_addr + cache_addr_t'(k);
                model[a]       = wr_data[k*word_bits +: word_bits];
                model_valid[a] = 1'b1;
            end
            written_bases.push_back(wr_addr);
            exp_wr_id.push_back(wr_id);
            exp_wr_cycle.push_back(check_latency ? cycle_count + 1 : -1);
            wr_taken = 1'b1;
        end
        if (rd_valid && rd_ready) begin
            exp_rd_id.push_back(rd_id);
            exp_rd_line.push_back(expected_line(rd_addr));
            rd_taken = 1'b1;
        end
    endtask

    task automatic write_line(input cache_addr_t addr, input cache_line_t data);
        next_cycle();
        start_write(addr, data);
        note_acceptance();
        while (wr_busy) begin
            next_cycle();
            note_acceptance();
        end
    endtask

    task automatic read_line(input cache_addr_t addr);
        next_cycle();
        start_read(addr);
        note_acceptance();
        while (rd_busy) begin
            next_cycle();
            note_acceptance();
        end
    endtask

    task automatic report_and_finish();
        $display("errors: %0d, acks missing: %0d, responses missing: %0d",
                 errors, exp_wr_id.size(), exp_rd_id.size());
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    always @(posedge clk) begin : check_outputs
        req_id_t     want_id;
        cache_line_t want_line;
        int          accepted_at;
        cycle_count = cycle_count + 1;
        if (!rst && wr_ack_valid) begin
            if (exp_wr_id.size() == 0) begin
                $display("A write acknowledge came with no write outstanding at %0t.", $time);
                errors++;
            end else begin
                want_id     = exp_wr_id.pop_front();
                accepted_at = exp_wr_cycle.pop_front();
                if (wr_ack_id !== want_id) begin
                    $display("[FAIL] %0t: wr_ack_id %0d, expected %0d", $time, wr_ack_id, want_id);
                    errors++;
                end
                if (accepted_at >= 0 && cycle_count - accepted_at != beats_per_line) begin
                    $display("[FAIL] %0t: write ack %0d cycles after acceptance, expected %0d",
                             $time, cycle_count - accepted_at, beats_per_line);
                    errors++;
                end
            end
            wr_busy = 1'b0;
        end
        if (!rst && rd_resp_valid) begin
            if (exp_rd_id.size() == 0) begin
                $display("A read response came with no read outstanding at %0t.", $time);
                errors++;
            end else begin
                want_id   = exp_rd_id.pop_front();
                want_line = exp_rd_line.pop_front();
                if (rd_resp_id !== want_id) begin
                    $display("[FAIL] %0t: rd_resp_id %0d, expected %0d", $time, rd_resp_id, want_id);
                    errors++;
                end
                if (rd_resp_data !== want_line) begin
                    $display("[FAIL] %0t: rd_resp_data %h, expected %h",
                             $time, rd_resp_data, want_line);
                    errors++;
                end
            end
            rd_busy = 1'b0;
        end
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run reached %0d cycles without finishing.", cycle_limit);
            errors++;
            report_and_finish();
        end
    end

    initial begin : stimulus
        cache_addr_t addr;
        int          wr_left;
        int          rd_left;
        int          idx;
        rst      = 1'b1;
        wr_valid = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        wr_id    = '0;
        rd_valid = 1'b0;
        rd_addr  = '0;
        rd_id    = '0;
        for (idx = 0; idx < 2**addr_bits; idx++) begin
            model_valid[idx] = 1'b0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (wr_ready !== 1'b1 || rd_ready !== 1'b1 ||
            wr_ack_valid !== 1'b0 || rd_resp_valid !== 1'b0) begin
            $display("[FAIL] %0t: ready or valid outputs wrong after reset", $time);
            errors++;
        end

        check_latency = 1'b1; // no read traffic while these writes run.
        write_line(10'd0, random_line());
        write_line(10'd4, random_line());
        write_line(10'd6, random_line());
        write_line(10'd100, random_line());
        check_latency = 1'b0;
        read_line(10'd0);
        read_line(10'd4);
        read_line(10'd3); // spans three written lines.
        read_line(10'd100);

        write_line(10'd1021, random_line());
        write_line(10'd1023, random_line());
        read_line(10'd1022);
        read_line(10'd1023);

        wr_left = random_ops;
        rd_left = random_ops;
        while (wr_left > 0 || rd_left > 0) begin
            next_cycle();
            if (!wr_busy && wr_left > 0 && ($random(seed) & 1)) begin
                addr = cache_addr_t'($random(seed) & 63);
                if (!(rd_busy && lines_overlap(addr, rd_busy_addr))) begin
                    start_write(addr, random_line());
                    wr_left--;
                end
            end
            if (!rd_busy && rd_left > 0 && ($random(seed) & 1)) begin
                idx  = ($random(seed) & 32'h7fff_ffff) % written_bases.size();
                addr = written_bases[idx];
                if (line_written(addr) && !(wr_busy && lines_overlap(addr, wr_busy_addr))) begin
                    start_read(addr);
                    rd_left--;
                end
            end
            note_acceptance();
        end
        while (wr_busy || rd_busy) begin
            next_cycle();
            note_acceptance();
        end
        next_cycle();
        if (!wr_ready || !rd_ready) begin
            $display("[FAIL] %0t: wr_ready or rd_ready low after all traffic", $time);
            errors++;
        end
        if (exp_wr_id.size() != 0 || exp_rd_id.size() != 0) begin
            $display("Some accepted requests never completed.");
            errors++;
        end
        report_and_finish();
    end

endmodule

/* sources.f */
cache_pkg.sv
cache_sram.sv
cache_port_arbiter.sv
cache_write_interface.sv
cache_read_interface.sv
cache_subsystem.sv
tb_cache_subsystem.sv
